//--- prf_pkg.sv
// shared word type and default sizing for the banked register file
// bank count must be a power of two and at least 2
// register count must be a multiple of the bank count

package prf_pkg;

    // ------------------------------------------------------------------------
    // data word

    localparam int DATA_WIDTH = 32;

    // one physical register value
    typedef logic [DATA_WIDTH-1:0] data_t;

    // ------------------------------------------------------------------------
    // default sizes, overridable at the top level

    // physical registers in total
    localparam int DEF_PR_COUNT = 64;

    // banks, selected by the low register number bits
    localparam int DEF_BANK_COUNT = 4;

    // read requesters sharing the two ports of each bank
    localparam int DEF_RR_COUNT = 4;

    // writeback requesters sharing the single write port of each bank
    localparam int DEF_WR_COUNT = 4;

endpackage

//--- prf_bank_ram.sv
// one bank of the register file, depth PR_COUNT / BANK_COUNT
// two asynchronous read ports, one clocked write port
// contents clear to zero on reset, no write-to-read bypass
`timescale 1ns/1ps

module prf_bank_ram #(
    parameter int PR_COUNT   = prf_pkg::DEF_PR_COUNT,
    parameter int BANK_COUNT = prf_pkg::DEF_BANK_COUNT,
    localparam int DEPTH     = PR_COUNT / BANK_COUNT,
    localparam int UPPER_W   = $clog2(PR_COUNT) - $clog2(BANK_COUNT)
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic [UPPER_W-1:0]  rd_index0,
    input  logic [UPPER_W-1:0]  rd_index1,
    output prf_pkg::data_t      rd_data0,
    output prf_pkg::data_t      rd_data1,
    input  logic                wr_en,
    input  logic [UPPER_W-1:0]  wr_index,
    input  prf_pkg::data_t      wr_data
);

    prf_pkg::data_t mem [DEPTH];

    // ------------------------------------------------------------------------
    // read ports

    // old value seen during the write cycle
    assign rd_data0 = mem[rd_index0];
    assign rd_data1 = mem[rd_index1];

    // ------------------------------------------------------------------------
    // write port

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

endmodule

//--- prf_arbiter.sv
// per-bank arbitration, highest requester index first
// fairness masks steer the next grant below the last winner
// read mask shared by all banks, write mask kept per bank
// grants are combinational from the merged request vectors
`timescale 1ns/1ps

module prf_arbiter #(
    parameter int BANK_COUNT = prf_pkg::DEF_BANK_COUNT,
    parameter int RR_COUNT   = prf_pkg::DEF_RR_COUNT,
    parameter int WR_COUNT   = prf_pkg::DEF_WR_COUNT
) (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic [BANK_COUNT-1:0][RR_COUNT-1:0] rd_valid_by_bank,
    input  logic [BANK_COUNT-1:0][WR_COUNT-1:0] wb_valid_by_bank,
    output logic [BANK_COUNT-1:0][RR_COUNT-1:0] rd_grant0_by_bank,
    output logic [BANK_COUNT-1:0][RR_COUNT-1:0] rd_grant1_by_bank,
    output logic [BANK_COUNT-1:0][WR_COUNT-1:0] wb_grant_by_bank,
    output logic [RR_COUNT-1:0]             reg_read_ack,
    output logic [RR_COUNT-1:0]             reg_read_port
);

    // common selector width covers both requester groups
    localparam int REQ_W = (RR_COUNT > WR_COUNT) ? RR_COUNT : WR_COUNT;

    // fairness state
    logic [RR_COUNT-1:0]                    rd_mask;
    logic [RR_COUNT-1:0]                    next_rd_mask;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0]    wb_mask;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0]    next_wb_mask;

    // ------------------------------------------------------------------------
    // selection

    // masked pool if it holds anything, else whole pool
    // msb wins, later hits override earlier ones
    function automatic logic [REQ_W-1:0] pick_highest(
        input logic [REQ_W-1:0] req,
        input logic [REQ_W-1:0] mask
    );
        logic [REQ_W-1:0] pool;
        pool = (|(req & mask)) ? (req & mask) : req;
        pick_highest = '0;
        for (int i = 0; i < REQ_W; i++) begin
            if (pool[i]) begin
                pick_highest = '0;
                pick_highest[i] = 1'b1;
            end
        end
    endfunction

    always_comb begin
        reg_read_ack = '0;
        reg_read_port = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            // port 0 first, port 1 repeats without port 0 winner
            rd_grant0_by_bank[b] = RR_COUNT'(pick_highest(REQ_W'(rd_valid_by_bank[b]),
                                                          REQ_W'(rd_mask)));
            rd_grant1_by_bank[b] = RR_COUNT'(pick_highest(
                REQ_W'(rd_valid_by_bank[b] & ~rd_grant0_by_bank[b]), REQ_W'(rd_mask)));
            wb_grant_by_bank[b] = WR_COUNT'(pick_highest(REQ_W'(wb_valid_by_bank[b]),
                                                         REQ_W'(wb_mask[b])));
            // a requester sits in one bank only, so or-ing is safe
            reg_read_ack |= rd_grant0_by_bank[b] | rd_grant1_by_bank[b];
            reg_read_port |= rd_grant1_by_bank[b];
        end
    end

    // ------------------------------------------------------------------------
    // fairness masks

    // read mask covers everything below highest ack, any bank or port
    always_comb begin
        next_rd_mask = '0;
        for (int r = RR_COUNT - 2; r >= 0; r--) begin
            next_rd_mask[r] = next_rd_mask[r+1] | reg_read_ack[r+1];
        end
    end

    // write mask per bank, below that bank's grant
    always_comb begin
        next_wb_mask = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int w = WR_COUNT - 2; w >= 0; w--) begin
                next_wb_mask[b][w] = next_wb_mask[b][w+1] | wb_grant_by_bank[b][w+1];
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_mask <= '0;
            wb_mask <= '0;
        end else begin
            rd_mask <= next_rd_mask;
            wb_mask <= next_wb_mask;
        end
    end

    // ------------------------------------------------------------------------
    // checks

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_chk
        // at most one winner per port
        a_grant_onehot: assert property (@(posedge CLK) disable iff (!nRST)
            $onehot0(rd_grant0_by_bank[b]) && $onehot0(rd_grant1_by_bank[b])
            && $onehot0(wb_grant_by_bank[b]));
        // one requester never holds both read ports
        a_ports_disjoint: assert property (@(posedge CLK) disable iff (!nRST)
            (rd_grant0_by_bank[b] & rd_grant1_by_bank[b]) == '0);
    end

endmodule

//--- prf_read_stage.sv
// keeps unacknowledged read requests and retries them every cycle
// a requester may not raise a new request while one is held
// bank read indexes are registered here, data follows from the RAM
`timescale 1ns/1ps

module prf_read_stage #(
    parameter int PR_COUNT   = prf_pkg::DEF_PR_COUNT,
    parameter int BANK_COUNT = prf_pkg::DEF_BANK_COUNT,
    parameter int RR_COUNT   = prf_pkg::DEF_RR_COUNT,
    localparam int LOG_PR    = $clog2(PR_COUNT),
    localparam int LOG_BANK  = $clog2(BANK_COUNT),
    localparam int UPPER_W   = LOG_PR - LOG_BANK
) (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic [RR_COUNT-1:0]                 reg_read_req_valid,
    input  logic [RR_COUNT-1:0][LOG_PR-1:0]     reg_read_req_pr,
    input  logic [BANK_COUNT-1:0][RR_COUNT-1:0] rd_grant0_by_bank,
    input  logic [BANK_COUNT-1:0][RR_COUNT-1:0] rd_grant1_by_bank,
    input  logic [RR_COUNT-1:0]                 reg_read_ack,
    output logic [BANK_COUNT-1:0][RR_COUNT-1:0] rd_valid_by_bank,
    output logic [BANK_COUNT-1:0][UPPER_W-1:0]  rd_index0_by_bank,
    output logic [BANK_COUNT-1:0][UPPER_W-1:0]  rd_index1_by_bank
);

    typedef logic [LOG_PR-1:0] pr_t;

    logic [RR_COUNT-1:0]                held_valid;
    pr_t [RR_COUNT-1:0]                 held_pr;
    logic [RR_COUNT-1:0]                merged_valid;
    pr_t [RR_COUNT-1:0]                 merged_pr;
    logic [BANK_COUNT-1:0][UPPER_W-1:0] next_index0;
    logic [BANK_COUNT-1:0][UPPER_W-1:0] next_index1;

    always_comb begin
        rd_valid_by_bank = '0;
        for (int r = 0; r < RR_COUNT; r++) begin
            merged_valid[r] = held_valid[r] | reg_read_req_valid[r];
            merged_pr[r] = held_valid[r] ? held_pr[r] : reg_read_req_pr[r];
            rd_valid_by_bank[merged_pr[r][LOG_BANK-1:0]][r] = merged_valid[r];
        end
    end

    // upper bits of each port winner
    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            next_index0[b] = '0;
            next_index1[b] = '0;
            for (int r = 0; r < RR_COUNT; r++) begin
                next_index0[b] |= merged_pr[r][LOG_PR-1:LOG_BANK]
                                  & {UPPER_W{rd_grant0_by_bank[b][r]}};
                next_index1[b] |= merged_pr[r][LOG_PR-1:LOG_BANK]
                                  & {UPPER_W{rd_grant1_by_bank[b][r]}};
            end
        end
    end

    // indexes reset so the RAM is read at entry 0 after reset
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            rd_index0_by_bank <= '0;
            rd_index1_by_bank <= '0;
        end else begin
            held_valid <= merged_valid & ~reg_read_ack;
            rd_index0_by_bank <= next_index0;
            rd_index1_by_bank <= next_index1;
        end
    end

    always_ff @(posedge CLK) begin
        held_pr <= merged_pr;
    end

    // requester waits for the ack before asking again
    a_no_new_while_held: assert property (@(posedge CLK) disable iff (!nRST)
        (held_valid & reg_read_req_valid) == '0);

endmodule

//--- prf_wb_stage.sv
// holds the oldest unacknowledged writeback of each requester
// wb_ready drops only when a held entry meets a new valid writeback
// the requester must then keep its inputs steady until wb_ready rises
// bank write registers also feed the writeback bus
`timescale 1ns/1ps

module prf_wb_stage #(
    parameter int PR_COUNT   = prf_pkg::DEF_PR_COUNT,
    parameter int BANK_COUNT = prf_pkg::DEF_BANK_COUNT,
    parameter int WR_COUNT   = prf_pkg::DEF_WR_COUNT,
    localparam int LOG_PR    = $clog2(PR_COUNT),
    localparam int LOG_BANK  = $clog2(BANK_COUNT),
    localparam int UPPER_W   = LOG_PR - LOG_BANK
) (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic [WR_COUNT-1:0]                 wb_valid,
    input  prf_pkg::data_t [WR_COUNT-1:0]       wb_data,
    input  logic [WR_COUNT-1:0][LOG_PR-1:0]     wb_pr,
    input  logic [BANK_COUNT-1:0][WR_COUNT-1:0] wb_grant_by_bank,
    output logic [WR_COUNT-1:0]                 wb_ready,
    output logic [BANK_COUNT-1:0][WR_COUNT-1:0] wb_valid_by_bank,
    output logic [BANK_COUNT-1:0]               wr_en_by_bank,
    output logic [BANK_COUNT-1:0][UPPER_W-1:0]  wr_index_by_bank,
    output prf_pkg::data_t [BANK_COUNT-1:0]     wr_data_by_bank
);

    typedef logic [LOG_PR-1:0]  pr_t;
    typedef logic [UPPER_W-1:0] upper_t;

    // held entry per requester
    logic [WR_COUNT-1:0]            held_valid;
    prf_pkg::data_t [WR_COUNT-1:0]  held_data;
    pr_t [WR_COUNT-1:0]             held_pr;

    // held entry takes precedence over the new one
    logic [WR_COUNT-1:0]            merged_valid;
    prf_pkg::data_t [WR_COUNT-1:0]  merged_data;
    pr_t [WR_COUNT-1:0]             merged_pr;
    logic [WR_COUNT-1:0]            wb_ack;

    prf_pkg::data_t [BANK_COUNT-1:0] next_wr_data;
    upper_t [BANK_COUNT-1:0]         next_wr_index;

    assign wb_ready = ~(wb_valid & held_valid);

    always_comb begin
        wb_valid_by_bank = '0;
        for (int w = 0; w < WR_COUNT; w++) begin
            merged_valid[w] = held_valid[w] | wb_valid[w];
            merged_data[w] = held_valid[w] ? held_data[w] : wb_data[w];
            merged_pr[w] = held_valid[w] ? held_pr[w] : wb_pr[w];
            // sort into bank by low register bits
            wb_valid_by_bank[merged_pr[w][LOG_BANK-1:0]][w] = merged_valid[w];
        end
    end

    always_comb begin
        wb_ack = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            wb_ack |= wb_grant_by_bank[b];
            // one-hot mux of the bank winner
            next_wr_data[b] = '0;
            next_wr_index[b] = '0;
            for (int w = 0; w < WR_COUNT; w++) begin
                next_wr_data[b] |= merged_data[w] & {prf_pkg::DATA_WIDTH{wb_grant_by_bank[b][w]}};
                next_wr_index[b] |= merged_pr[w][LOG_PR-1:LOG_BANK]
                                    & {UPPER_W{wb_grant_by_bank[b][w]}};
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            wr_en_by_bank <= '0;
        end else begin
            held_valid <= merged_valid & ~wb_ack;
            for (int b = 0; b < BANK_COUNT; b++) begin
                wr_en_by_bank[b] <= |wb_grant_by_bank[b];
            end
        end
    end

    // payload, qualified by the valid bits above
    always_ff @(posedge CLK) begin
        held_data <= merged_data;
        held_pr <= merged_pr;
        wr_data_by_bank <= next_wr_data;
        wr_index_by_bank <= next_wr_index;
    end

    // stalled requester keeps the same writeback on its inputs
    for (genvar w = 0; w < WR_COUNT; w++) begin : g_chk
        a_stall_held: assert property (@(posedge CLK) disable iff (!nRST)
            !wb_ready[w] |=> wb_valid[w] && $stable(wb_pr[w]) && $stable(wb_data[w]));
    end

endmodule

//--- prf.sv
// banked physical register file, 2 read ports and 1 write port per bank
// read ack is combinational, read data follows one cycle after the ack
// writeback shows on the bus one cycle after grant, readable a cycle later
// no write-to-read bypass, same-cycle read of a written register is old
`timescale 1ns/1ps

module prf #(
    parameter int PR_COUNT   = prf_pkg::DEF_PR_COUNT,
    parameter int BANK_COUNT = prf_pkg::DEF_BANK_COUNT,
    parameter int RR_COUNT   = prf_pkg::DEF_RR_COUNT,
    parameter int WR_COUNT   = prf_pkg::DEF_WR_COUNT,
    localparam int LOG_PR    = $clog2(PR_COUNT),
    localparam int UPPER_W   = LOG_PR - $clog2(BANK_COUNT)
) (
    input  logic                                        CLK,
    input  logic                                        nRST,
    // read requests
    input  logic [RR_COUNT-1:0]                         reg_read_req_valid,
    input  logic [RR_COUNT-1:0][LOG_PR-1:0]             reg_read_req_pr,
    output logic [RR_COUNT-1:0]                         reg_read_ack,
    output logic [RR_COUNT-1:0]                         reg_read_port,
    output prf_pkg::data_t [BANK_COUNT-1:0][1:0]        reg_read_data,
    // writeback requests
    input  logic [WR_COUNT-1:0]                         wb_valid,
    input  prf_pkg::data_t [WR_COUNT-1:0]               wb_data,
    input  logic [WR_COUNT-1:0][LOG_PR-1:0]             wb_pr,
    output logic [WR_COUNT-1:0]                         wb_ready,
    // writeback bus, one lane per bank
    output logic [BANK_COUNT-1:0]                       wb_bus_valid,
    output prf_pkg::data_t [BANK_COUNT-1:0]             wb_bus_data,
    output logic [BANK_COUNT-1:0][UPPER_W-1:0]          wb_bus_upper_pr
);

    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    rd_valid_by_bank;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    rd_grant0_by_bank;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0]    rd_grant1_by_bank;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0]    wb_valid_by_bank;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0]    wb_grant_by_bank;
    logic [BANK_COUNT-1:0][UPPER_W-1:0]     rd_index0_by_bank;
    logic [BANK_COUNT-1:0][UPPER_W-1:0]     rd_index1_by_bank;

    prf_arbiter #(.BANK_COUNT(BANK_COUNT), .RR_COUNT(RR_COUNT), .WR_COUNT(WR_COUNT)) u_arbiter (
        .CLK(CLK), .nRST(nRST),
        .rd_valid_by_bank(rd_valid_by_bank), .wb_valid_by_bank(wb_valid_by_bank),
        .rd_grant0_by_bank(rd_grant0_by_bank), .rd_grant1_by_bank(rd_grant1_by_bank),
        .wb_grant_by_bank(wb_grant_by_bank),
        .reg_read_ack(reg_read_ack), .reg_read_port(reg_read_port)
    );

    prf_read_stage #(.PR_COUNT(PR_COUNT), .BANK_COUNT(BANK_COUNT), .RR_COUNT(RR_COUNT)) u_read (
        .CLK(CLK), .nRST(nRST),
        .reg_read_req_valid(reg_read_req_valid), .reg_read_req_pr(reg_read_req_pr),
        .rd_grant0_by_bank(rd_grant0_by_bank), .rd_grant1_by_bank(rd_grant1_by_bank),
        .reg_read_ack(reg_read_ack), .rd_valid_by_bank(rd_valid_by_bank),
        .rd_index0_by_bank(rd_index0_by_bank), .rd_index1_by_bank(rd_index1_by_bank)
    );

    // registered bank writes double as the writeback bus
    prf_wb_stage #(.PR_COUNT(PR_COUNT), .BANK_COUNT(BANK_COUNT), .WR_COUNT(WR_COUNT)) u_wb (
        .CLK(CLK), .nRST(nRST),
        .wb_valid(wb_valid), .wb_data(wb_data), .wb_pr(wb_pr),
        .wb_grant_by_bank(wb_grant_by_bank), .wb_ready(wb_ready),
        .wb_valid_by_bank(wb_valid_by_bank), .wr_en_by_bank(wb_bus_valid),
        .wr_index_by_bank(wb_bus_upper_pr), .wr_data_by_bank(wb_bus_data)
    );

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        prf_bank_ram #(.PR_COUNT(PR_COUNT), .BANK_COUNT(BANK_COUNT)) u_ram (
            .CLK(CLK), .nRST(nRST),
            .rd_index0(rd_index0_by_bank[b]), .rd_index1(rd_index1_by_bank[b]),
            .rd_data0(reg_read_data[b][0]), .rd_data1(reg_read_data[b][1]),
            .wr_en(wb_bus_valid[b]), .wr_index(wb_bus_upper_pr[b]),
            .wr_data(wb_bus_data[b])
        );
    end

endmodule

//--- tb_prf.sv
// table-driven testbench, one table row per clock cycle
// assumes the default sizes, 4 banks with 4 read and 4 writeback requesters
// expected read data comes from a shadow copy of accepted writebacks
// rows keep each read at least two cycles behind the writeback it reads
`timescale 1ns/1ps

module tb_prf;

    localparam int PR_COUNT     = prf_pkg::DEF_PR_COUNT;
    localparam int BANK_COUNT   = prf_pkg::DEF_BANK_COUNT;
    localparam int RR_COUNT     = prf_pkg::DEF_RR_COUNT;
    localparam int WR_COUNT     = prf_pkg::DEF_WR_COUNT;
    localparam int LOG_PR       = $clog2(PR_COUNT);
    localparam int LOG_BANK     = $clog2(BANK_COUNT);
    localparam int UPPER_W      = LOG_PR - LOG_BANK;
    localparam int GROUPS       = PR_COUNT / BANK_COUNT;
    localparam int MAX_ROWS     = 64;
    localparam int RESET_CYCLES = 10;

    // one register number per requester or per bank lane
    typedef logic [RR_COUNT-1:0][LOG_PR-1:0] pr_vec_t;

    logic                                   CLK;
    logic                                   nRST;
    logic [RR_COUNT-1:0]                    reg_read_req_valid;
    logic [RR_COUNT-1:0][LOG_PR-1:0]        reg_read_req_pr;
    logic [RR_COUNT-1:0]                    reg_read_ack;
    logic [RR_COUNT-1:0]                    reg_read_port;
    prf_pkg::data_t [BANK_COUNT-1:0][1:0]   reg_read_data;
    logic [WR_COUNT-1:0]                    wb_valid;
    prf_pkg::data_t [WR_COUNT-1:0]          wb_data;
    logic [WR_COUNT-1:0][LOG_PR-1:0]        wb_pr;
    logic [WR_COUNT-1:0]                    wb_ready;
    logic [BANK_COUNT-1:0]                  wb_bus_valid;
    prf_pkg::data_t [BANK_COUNT-1:0]        wb_bus_data;
    logic [BANK_COUNT-1:0][UPPER_W-1:0]     wb_bus_upper_pr;

    // stimulus and expected values, one entry per cycle
    string                  row_name [MAX_ROWS];
    logic [WR_COUNT-1:0]    row_wv [MAX_ROWS];
    pr_vec_t                row_wpr [MAX_ROWS];
    prf_pkg::data_t         row_wdata [MAX_ROWS][WR_COUNT];
    logic [RR_COUNT-1:0]    row_rv [MAX_ROWS];
    pr_vec_t                row_rpr [MAX_ROWS];
    logic [WR_COUNT-1:0]    row_ready [MAX_ROWS];
    logic [RR_COUNT-1:0]    row_ack [MAX_ROWS];
    logic [RR_COUNT-1:0]    row_port [MAX_ROWS];
    logic [BANK_COUNT-1:0]  row_bus [MAX_ROWS];
    pr_vec_t                row_bus_pr [MAX_ROWS];

    // shadow model, held reads and data checks due next cycle
    prf_pkg::data_t         shadow [PR_COUNT];
    logic [RR_COUNT-1:0]    held_rd;
    logic [LOG_PR-1:0]      held_rd_pr [RR_COUNT];
    logic [RR_COUNT-1:0]    chk_valid;
    logic [LOG_PR-1:0]      chk_pr [RR_COUNT];
    logic                   chk_port [RR_COUNT];
    prf_pkg::data_t         chk_exp [RR_COUNT];

    int     n_rows;
    int     errors;
    int     row_errors;
    int     tests_passed;
    int     tests_failed;
    int     cycle_count;
    int     cycle_limit;
    integer seed;

    prf #(.PR_COUNT(PR_COUNT), .BANK_COUNT(BANK_COUNT), .RR_COUNT(RR_COUNT),
          .WR_COUNT(WR_COUNT)) UUT (
        .CLK(CLK), .nRST(nRST),
        .reg_read_req_valid(reg_read_req_valid), .reg_read_req_pr(reg_read_req_pr),
        .reg_read_ack(reg_read_ack), .reg_read_port(reg_read_port),
        .reg_read_data(reg_read_data),
        .wb_valid(wb_valid), .wb_data(wb_data), .wb_pr(wb_pr), .wb_ready(wb_ready),
        .wb_bus_valid(wb_bus_valid), .wb_bus_data(wb_bus_data),
        .wb_bus_upper_pr(wb_bus_upper_pr)
    );

    always #10 CLK = ~CLK;

    // run limit, eight cycles per row plus reset
    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // table building

    // a requester that was stalled repeats its data from the row before
    task automatic add_row(input string name, input logic [3:0] wv, input pr_vec_t wpr,
                           input logic [3:0] rv, input pr_vec_t rpr,
                           input logic [3:0] ready, input logic [3:0] ack,
                           input logic [3:0] port, input logic [3:0] bus,
                           input pr_vec_t bus_pr);
        row_name[n_rows] = name;
        row_wv[n_rows] = wv;
        row_wpr[n_rows] = wpr;
        row_rv[n_rows] = rv;
        row_rpr[n_rows] = rpr;
        row_ready[n_rows] = ready;
        row_ack[n_rows] = ack;
        row_port[n_rows] = port;
        row_bus[n_rows] = bus;
        row_bus_pr[n_rows] = bus_pr;
        for (int w = 0; w < WR_COUNT; w++) begin
            if (n_rows > 0 && row_wv[n_rows-1][w] && !row_ready[n_rows-1][w]) begin
                row_wdata[n_rows][w] = row_wdata[n_rows-1][w];
            end else begin
                row_wdata[n_rows][w] = $random(seed);
            end
        end
        n_rows++;
    endtask

    // args: write valid/regs, read valid/regs, ready, ack, port, bus lanes/regs
    task automatic build_table();
        pr_vec_t pr;
        pr_vec_t prev;
        add_row("reset_idle", 4'b0000, '0, 4'b0000, '0, 4'b1111, 4'b0000, 4'b0000, 4'b0000, '0);
        add_row("reset_read", 4'b0000, '0, 4'b1111, {6'd15, 6'd10, 6'd5, 6'd0},
                4'b1111, 4'b1111, 4'b0000, 4'b0000, '0);
        // single writeback, then its bus lane, then the read
        add_row("wb_single", 4'b0100, {6'd0, 6'd9, 6'd0, 6'd0}, 4'b0000, '0,
                4'b1111, 4'b0000, 4'b0000, 4'b0000, '0);
        add_row("wb_single", 4'b0000, '0, 4'b0000, '0,
                4'b1111, 4'b0000, 4'b0000, 4'b0010, {6'd0, 6'd0, 6'd9, 6'd0});
        add_row("wb_single", 4'b0000, '0, 4'b0001, {6'd0, 6'd0, 6'd0, 6'd9},
                4'b1111, 4'b0001, 4'b0000, 4'b0000, '0);
        // bank 2 contention, requester 3 ahead of requester 1
        add_row("wb_same_bank", 4'b1010, {6'd6, 6'd0, 6'd14, 6'd0}, 4'b0000, '0,
                4'b1111, 4'b0000, 4'b0000, 4'b0000, '0);
        add_row("wb_same_bank", 4'b0000, '0, 4'b0000, '0,
                4'b1111, 4'b0000, 4'b0000, 4'b0100, {6'd0, 6'd6, 6'd0, 6'd0});
        add_row("wb_same_bank", 4'b0000, '0, 4'b0000, '0,
                4'b1111, 4'b0000, 4'b0000, 4'b0100, {6'd0, 6'd14, 6'd0, 6'd0});
        add_row("wb_same_bank", 4'b0000, '0, 4'b0011, {6'd0, 6'd0, 6'd14, 6'd6},
                4'b1111, 4'b0011, 4'b0001, 4'b0000, '0);
        // requester 0 loses bank 3, then stalls on a new writeback
        add_row("wb_stall", 4'b0101, {6'd0, 6'd3, 6'd0, 6'd7}, 4'b0000, '0,
                4'b1111, 4'b0000, 4'b0000, 4'b0000, '0);
        add_row("wb_stall", 4'b0001, {6'd0, 6'd0, 6'd0, 6'd11}, 4'b0000, '0,
                4'b1110, 4'b0000, 4'b0000, 4'b1000, {6'd3, 6'd0, 6'd0, 6'd0});
        add_row("wb_stall", 4'b0001, {6'd0, 6'd0, 6'd0, 6'd11}, 4'b0000, '0,
                4'b1111, 4'b0000, 4'b0000, 4'b1000, {6'd7, 6'd0, 6'd0, 6'd0});
        add_row("wb_stall", 4'b0000, '0, 4'b0000, '0,
                4'b1111, 4'b0000, 4'b0000, 4'b1000, {6'd11, 6'd0, 6'd0, 6'd0});
        add_row("wb_stall", 4'b0000, '0, 4'b1100, {6'd7, 6'd9, 6'd0, 6'd0},
                4'b1111, 4'b1100, 4'b0000, 4'b0000, '0);
        add_row("wb_stall", 4'b0000, '0, 4'b0011, {6'd0, 6'd0, 6'd11, 6'd14},
                4'b1111, 4'b0011, 4'b0000, 4'b0000, '0);
        // three reads on bank 2, requester 1 waits a cycle
        add_row("read_three", 4'b0000, '0, 4'b1110, {6'd6, 6'd14, 6'd2, 6'd0},
                4'b1111, 4'b1100, 4'b0100, 4'b0000, '0);
        add_row("read_three", 4'b0000, '0, 4'b0000, '0, 4'b1111, 4'b0010, 4'b0000, 4'b0000, '0);
        add_row("read_three", 4'b0000, '0, 4'b0000, '0, 4'b1111, 4'b0000, 4'b0000, 4'b0000, '0);
        // every register once, each requester on its own bank per row
        for (int c = 0; c < GROUPS; c++) begin
            for (int k = 0; k < BANK_COUNT; k++) begin
                pr[k] = LOG_PR'(BANK_COUNT * c + (k + c) % BANK_COUNT);
                prev[k] = LOG_PR'(BANK_COUNT * c - BANK_COUNT + k);
            end
            add_row("rand_wb", 4'b1111, pr, 4'b0000, '0, 4'b1111, 4'b0000, 4'b0000,
                    (c > 0) ? 4'b1111 : 4'b0000, prev);
        end
        for (int c = 0; c < GROUPS; c++) begin
            for (int k = 0; k < BANK_COUNT; k++) begin
                pr[k] = LOG_PR'(BANK_COUNT * c + (k + c) % BANK_COUNT);
                prev[k] = LOG_PR'(PR_COUNT - BANK_COUNT + k);
            end
            add_row("rand_rd", 4'b0000, '0, 4'b1111, pr, 4'b1111, 4'b1111, 4'b0000,
                    (c == 0) ? 4'b1111 : 4'b0000, prev);
        end
        add_row("drain", 4'b0000, '0, 4'b0000, '0, 4'b1111, 4'b0000, 4'b0000, 4'b0000, '0);
    endtask

    // ------------------------------------------------------------------------
    // checking

    task automatic value_error(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        $display("** Error %s: %s expected %h, actual %h", test, what, exp, act);
        errors++;
        row_errors++;
    endtask

    // combinational handshake outputs and the registered bus lanes
    task automatic check_outputs(input int i);
        logic [LOG_PR-1:0] bpr;
        if (wb_ready !== row_ready[i])
            value_error(row_name[i], "wb_ready", 32'(row_ready[i]), 32'(wb_ready));
        if (reg_read_ack !== row_ack[i])
            value_error(row_name[i], "reg_read_ack", 32'(row_ack[i]), 32'(reg_read_ack));
        if (reg_read_port !== row_port[i])
            value_error(row_name[i], "reg_read_port", 32'(row_port[i]), 32'(reg_read_port));
        if (wb_bus_valid !== row_bus[i])
            value_error(row_name[i], "wb_bus_valid", 32'(row_bus[i]), 32'(wb_bus_valid));
        for (int b = 0; b < BANK_COUNT; b++) begin
            bpr = row_bus_pr[i][b];
            if (row_bus[i][b] && wb_bus_upper_pr[b] !== bpr[LOG_PR-1:LOG_BANK])
                value_error(row_name[i], $sformatf("bus %0d upper reg", b),
                            32'(bpr[LOG_PR-1:LOG_BANK]), 32'(wb_bus_upper_pr[b]));
            if (row_bus[i][b] && wb_bus_data[b] !== shadow[bpr])
                value_error(row_name[i], $sformatf("bus %0d data", b), shadow[bpr],
                            wb_bus_data[b]);
        end
    endtask

    // expected reads use the table acks, shadow takes accepted writebacks
    task automatic update_model(input int i);
        logic              eff_valid;
        logic [LOG_PR-1:0] eff_pr;
        for (int r = 0; r < RR_COUNT; r++) begin
            eff_valid = held_rd[r] | row_rv[i][r];
            eff_pr = held_rd[r] ? held_rd_pr[r] : row_rpr[i][r];
            if (row_ack[i][r]) begin
                chk_valid[r] = 1'b1;
                chk_pr[r] = eff_pr;
                chk_port[r] = row_port[i][r];
                chk_exp[r] = shadow[eff_pr];
            end
            held_rd[r] = eff_valid & ~row_ack[i][r];
            held_rd_pr[r] = eff_pr;
        end
        for (int w = 0; w < WR_COUNT; w++) begin
            if (row_wv[i][w] && row_ready[i][w])
                shadow[row_wpr[i][w]] = row_wdata[i][w];
        end
    endtask

    // data for the reads acked in row i, one cycle later
    task automatic check_read_data(input int i);
        prf_pkg::data_t act;
        for (int r = 0; r < RR_COUNT; r++) begin
            act = reg_read_data[chk_pr[r][LOG_BANK-1:0]][chk_port[r]];
            if (chk_valid[r] && act !== chk_exp[r])
                value_error(row_name[i], $sformatf("read data, requester %0d reg %0d",
                            r, chk_pr[r]), chk_exp[r], act);
        end
        chk_valid = '0;
    endtask

    task automatic report_row(input int i);
        if (row_errors == 0) begin
            tests_passed++;
            $display("row %0d %s passed", i, row_name[i]);
        end else begin
            tests_failed++;
            $display("row %0d %s failed with %0d errors", i, row_name[i], row_errors);
        end
        row_errors = 0;
    endtask

    // ------------------------------------------------------------------------
    // main sequence

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        reg_read_req_valid = '0;
        reg_read_req_pr = '0;
        wb_valid = '0;
        wb_data = '0;
        wb_pr = '0;
        seed = 98;
        n_rows = 0;
        errors = 0;
        row_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count = 0;
        held_rd = '0;
        chk_valid = '0;
        for (int p = 0; p < PR_COUNT; p++)
            shadow[p] = '0;
        build_table();
        cycle_limit = 8 * n_rows + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            @(negedge CLK);
            if (i > 0) begin
                check_read_data(i - 1);
                report_row(i - 1);
            end
            // drive the row, then sample once the inputs have settled
            reg_read_req_valid = row_rv[i];
            reg_read_req_pr = row_rpr[i];
            wb_valid = row_wv[i];
            wb_pr = row_wpr[i];
            for (int w = 0; w < WR_COUNT; w++)
                wb_data[w] = row_wdata[i][w];
            #5;
            check_outputs(i);
            update_model(i);
        end
        @(negedge CLK);
        check_read_data(n_rows - 1);
        report_row(n_rows - 1);
        $display("%0d tests, %0d passed, %0d failed, %0d errors", n_rows, tests_passed,
                 tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
prf_pkg.sv
prf_bank_ram.sv
prf_arbiter.sv
prf_read_stage.sv
prf_wb_stage.sv
prf.sv
tb_prf.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it, then searches the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
    --top-module tb_prf -Mdir obj_dir -o tb_prf > build.log 2>&1 \
    && ./obj_dir/tb_prf > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Test FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
